/* rtl/riscv_defines.sv */
package riscv_defines;

    // major opcodes handled by the execute stage
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // branch conditions, 3'b010 and 3'b011 are unused by the ISA
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [6:0] F7_BASE   = 7'b0000000;
    localparam logic [6:0] F7_ALT    = 7'b0100000;
    localparam logic [6:0] F7_MULDIV = 7'b0000001;

    typedef enum logic [4:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_MUL,
        ALU_MULH,
        ALU_MULHSU,
        ALU_MULHU,
        ALU_DIV,
        ALU_DIVU,
        ALU_REM,
        ALU_REMU
    } alucontrol_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // the B-type immediate is scattered over the word, bit 0 is implied zero
    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        b_fmt_t b_fmt;
    } instr_t;

endpackage

/* rtl/alu_decoder.sv */
module alu_decoder (
    input  riscv_defines::instr_t      instr,
    input  logic [31:0]                rs2_val,
    output riscv_defines::alucontrol_t alucontrol,
    output logic [31:0]                op_b,
    output logic                       reg_write,
    output logic                       is_branch,
    output logic                       illegal_op
);

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] imm;
    logic        use_imm;
    logic        is_alu;

    assign opcode = instr.r_fmt.opcode;
    assign funct3 = instr.r_fmt.funct3;
    assign funct7 = instr.r_fmt.funct7;

    assign imm  = {{20{instr.i_fmt.imm12[11]}}, instr.i_fmt.imm12};
    assign op_b = use_imm ? imm : rs2_val;

    always_comb begin
        alucontrol = riscv_defines::ALU_ADD;
        use_imm    = 1'b0;
        is_alu     = 1'b0;
        is_branch  = 1'b0;
        illegal_op = 1'b0;
        case (opcode)
            riscv_defines::OPC_OP: begin
                is_alu = 1'b1;
                case (funct7)
                    riscv_defines::F7_BASE: begin
                        case (funct3)
                            3'b000:  alucontrol = riscv_defines::ALU_ADD;
                            3'b001:  alucontrol = riscv_defines::ALU_SLL;
                            3'b010:  alucontrol = riscv_defines::ALU_SLT;
                            3'b011:  alucontrol = riscv_defines::ALU_SLTU;
                            3'b100:  alucontrol = riscv_defines::ALU_XOR;
                            3'b101:  alucontrol = riscv_defines::ALU_SRL;
                            3'b110:  alucontrol = riscv_defines::ALU_OR;
                            default: alucontrol = riscv_defines::ALU_AND;
                        endcase
                    end
                    riscv_defines::F7_ALT: begin
                        if (funct3 == 3'b000) begin
                            alucontrol = riscv_defines::ALU_SUB;
                        end else if (funct3 == 3'b101) begin
                            alucontrol = riscv_defines::ALU_SRA;
                        end else begin
                            illegal_op = 1'b1;
                        end
                    end
                    riscv_defines::F7_MULDIV: begin
                        case (funct3)
                            3'b000:  alucontrol = riscv_defines::ALU_MUL;
                            3'b001:  alucontrol = riscv_defines::ALU_MULH;
                            3'b010:  alucontrol = riscv_defines::ALU_MULHSU;
                            3'b011:  alucontrol = riscv_defines::ALU_MULHU;
                            3'b100:  alucontrol = riscv_defines::ALU_DIV;
                            3'b101:  alucontrol = riscv_defines::ALU_DIVU;
                            3'b110:  alucontrol = riscv_defines::ALU_REM;
                            default: alucontrol = riscv_defines::ALU_REMU;
                        endcase
                    end
                    default: illegal_op = 1'b1;
                endcase
            end
            riscv_defines::OPC_OP_IMM: begin
                is_alu  = 1'b1;
                use_imm = 1'b1;
                // funct3 000 is always addi, there is no subtract with an immediate
                case (funct3)
                    3'b000:  alucontrol = riscv_defines::ALU_ADD;
                    3'b010:  alucontrol = riscv_defines::ALU_SLT;
                    3'b011:  alucontrol = riscv_defines::ALU_SLTU;
                    3'b100:  alucontrol = riscv_defines::ALU_XOR;
                    3'b110:  alucontrol = riscv_defines::ALU_OR;
                    3'b111:  alucontrol = riscv_defines::ALU_AND;
                    3'b001: begin
                        alucontrol = riscv_defines::ALU_SLL;
                        illegal_op = (funct7 != riscv_defines::F7_BASE);
                    end
                    default: begin
                        // shift right, funct7 bit 5 picks arithmetic
                        alucontrol = funct7[5] ? riscv_defines::ALU_SRA
                                               : riscv_defines::ALU_SRL;
                        illegal_op = (funct7 != riscv_defines::F7_BASE) &&
                                     (funct7 != riscv_defines::F7_ALT);
                    end
                endcase
            end
            riscv_defines::OPC_BRANCH: begin
                is_branch  = 1'b1;
                illegal_op = (funct3 == 3'b010) || (funct3 == 3'b011);
            end
            default: illegal_op = 1'b1;
        endcase
    end

    // writes to x0 are dropped here so later stages never see them
    assign reg_write = is_alu && !illegal_op && (instr.r_fmt.rd != 5'd0);

endmodule

/* rtl/alu.sv */
module alu (
    input  logic [31:0]                in_a,
    input  logic [31:0]                in_b,
    input  riscv_defines::alucontrol_t alucontrol,
    output logic [31:0]                aluresult
);

    logic [4:0]  shamt;
    logic [63:0] mul;
    logic [63:0] mulsu;
    logic [63:0] mulu;
    logic        div_zero;
    logic        overflow_cond;

    assign shamt = in_b[4:0];

    assign mul   = $signed(in_a) * $signed(in_b);
    // 33-bit operands keep in_a signed and in_b unsigned in one signed product
    assign mulsu = $signed({in_a[31], in_a}) * $signed({1'b0, in_b});
    assign mulu  = in_a * in_b;

    assign div_zero      = (in_b == 32'b0);
    assign overflow_cond = (in_a == 32'h8000_0000) && (in_b == 32'hFFFF_FFFF);

    always_comb begin
        case (alucontrol)
            riscv_defines::ALU_ADD:    aluresult = in_a + in_b;
            riscv_defines::ALU_SUB:    aluresult = in_a - in_b;
            riscv_defines::ALU_SLT:    aluresult = {31'b0, $signed(in_a) < $signed(in_b)};
            riscv_defines::ALU_SLTU:   aluresult = {31'b0, in_a < in_b};
            riscv_defines::ALU_XOR:    aluresult = in_a ^ in_b;
            riscv_defines::ALU_OR:     aluresult = in_a | in_b;
            riscv_defines::ALU_AND:    aluresult = in_a & in_b;
            riscv_defines::ALU_SLL:    aluresult = in_a << shamt;
            riscv_defines::ALU_SRL:    aluresult = in_a >> shamt;
            riscv_defines::ALU_SRA:    aluresult = $signed(in_a) >>> shamt;
            riscv_defines::ALU_MUL:    aluresult = mul[31:0];
            riscv_defines::ALU_MULH:   aluresult = mul[63:32];
            riscv_defines::ALU_MULHSU: aluresult = mulsu[63:32];
            riscv_defines::ALU_MULHU:  aluresult = mulu[63:32];
            riscv_defines::ALU_DIV: begin
                if (div_zero)           aluresult = 32'hFFFF_FFFF;
                else if (overflow_cond) aluresult = 32'h8000_0000;
                else                    aluresult = $signed(in_a) / $signed(in_b);
            end
            riscv_defines::ALU_DIVU: begin
                if (div_zero)           aluresult = 32'hFFFF_FFFF;
                else                    aluresult = in_a / in_b;
            end
            riscv_defines::ALU_REM: begin
                if (div_zero)           aluresult = in_a;
                else if (overflow_cond) aluresult = 32'b0;
                else                    aluresult = $signed(in_a) % $signed(in_b);
            end
            riscv_defines::ALU_REMU: begin
                if (div_zero)           aluresult = in_a;
                else                    aluresult = in_a % in_b;
            end
            default:                    aluresult = 32'b0;
        endcase
    end

endmodule

/* rtl/branch_unit.sv */
module branch_unit (
    input  riscv_defines::instr_t instr,
    input  logic [31:0]           pc,
    input  logic [31:0]           rs1_val,
    input  logic [31:0]           rs2_val,
    output logic                  taken,
    output logic [31:0]           target
);

    logic        eq;
    logic        lt;
    logic        ltu;
    logic [12:0] b_imm;

    assign eq  = (rs1_val == rs2_val);
    assign lt  = ($signed(rs1_val) < $signed(rs2_val));
    assign ltu = (rs1_val < rs2_val);

    assign b_imm = {
        instr.b_fmt.imm_12,
        instr.b_fmt.imm_11,
        instr.b_fmt.imm_10_5,
        instr.b_fmt.imm_4_1,
        1'b0
    };

    assign target = pc + {{19{b_imm[12]}}, b_imm};

    // raw condition, whether this is a legal branch at all is decided downstream
    always_comb begin
        case (instr.b_fmt.funct3)
            riscv_defines::F3_BEQ:  taken = eq;
            riscv_defines::F3_BNE:  taken = !eq;
            riscv_defines::F3_BLT:  taken = lt;
            riscv_defines::F3_BGE:  taken = !lt;
            riscv_defines::F3_BLTU: taken = ltu;
            riscv_defines::F3_BGEU: taken = !ltu;
            default:                taken = 1'b0;
        endcase
    end

endmodule

/* rtl/exec_result.sv */
module exec_result (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        in_valid,
    input  logic [31:0] pc,
    input  logic [31:0] aluresult,
    input  logic        reg_write,
    input  logic        is_branch,
    input  logic        illegal_op,
    input  logic        taken,
    input  logic [31:0] target,
    output logic        out_valid,
    output logic [31:0] rd_data,
    output logic        rd_write,
    output logic [31:0] next_pc,
    output logic        illegal
);

    logic        redirect;
    logic [31:0] pc_plus4;

    // an illegal branch falls through like any other bad instruction
    assign redirect = is_branch && taken && !illegal_op;
    assign pc_plus4 = pc + 32'd4;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // results hold between strobes so they stay stable after the pulse
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_data  <= 32'b0;
            rd_write <= 1'b0;
            next_pc  <= 32'b0;
            illegal  <= 1'b0;
        end else if (in_valid) begin
            rd_data  <= aluresult;
            rd_write <= reg_write;
            next_pc  <= redirect ? target : pc_plus4;
            illegal  <= illegal_op;
        end
    end

endmodule

/* rtl/exec_stage.sv */
module exec_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    input  riscv_defines::instr_t instr,
    input  logic [31:0]           pc,
    input  logic [31:0]           rs1_val,
    input  logic [31:0]           rs2_val,
    output logic                  out_valid,
    output logic [31:0]           rd_data,
    output logic                  rd_write,
    output logic [31:0]           next_pc,
    output logic                  illegal
);

    riscv_defines::alucontrol_t alucontrol;
    logic [31:0]                op_b;
    logic                       reg_write;
    logic                       is_branch;
    logic                       illegal_op;
    logic [31:0]                aluresult;
    logic                       taken;
    logic [31:0]                target;

    alu_decoder i_alu_decoder (
        .instr      (instr),
        .rs2_val    (rs2_val),
        .alucontrol (alucontrol),
        .op_b       (op_b),
        .reg_write  (reg_write),
        .is_branch  (is_branch),
        .illegal_op (illegal_op)
    );

    alu i_alu (
        .in_a       (rs1_val),
        .in_b       (op_b),
        .alucontrol (alucontrol),
        .aluresult  (aluresult)
    );

    branch_unit i_branch_unit (
        .instr   (instr),
        .pc      (pc),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val),
        .taken   (taken),
        .target  (target)
    );

    exec_result i_exec_result (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .pc         (pc),
        .aluresult  (aluresult),
        .reg_write  (reg_write),
        .is_branch  (is_branch),
        .illegal_op (illegal_op),
        .taken      (taken),
        .target     (target),
        .out_valid  (out_valid),
        .rd_data    (rd_data),
        .rd_write   (rd_write),
        .next_pc    (next_pc),
        .illegal    (illegal)
    );

endmodule

/* dv/exec_stage_props.sv */
module exec_stage_props (
    input logic clk,
    input logic rst_n,
    input logic in_valid,
    input logic out_valid,
    input logic rd_write,
    input logic illegal
);

    int fail_count = 0;

    a_quiet_in_reset: assert property (
        @(posedge clk) !rst_n |-> !out_valid
    ) else begin
        $error("out_valid high while reset is asserted");
        fail_count++;
    end

    // the output strobe is the input strobe delayed by exactly one cycle
    a_strobe_delay: assert property (
        @(posedge clk) disable iff (!rst_n) out_valid == $past(in_valid)
    ) else begin
        $error("out_valid does not follow in_valid by one cycle");
        fail_count++;
    end

    a_no_write_when_illegal: assert property (
        @(posedge clk) disable iff (!rst_n) !(illegal && rd_write)
    ) else begin
        $error("rd_write and illegal are high together");
        fail_count++;
    end

endmodule

bind exec_stage exec_stage_props i_exec_stage_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .rd_write  (rd_write),
    .illegal   (illegal)
);

/* dv/exec_stage_tb.sv */
module exec_stage_tb;

    // the timeout allows one idle cycle per strobe over the five random tests
    localparam int total_strobes = 4 * 400 + 200;
    localparam int cycle_limit   = total_strobes * 2 + 200;

    logic                  clk;
    logic                  rst_n;
    logic                  in_valid;
    riscv_defines::instr_t instr;
    logic [31:0]           pc;
    logic [31:0]           rs1_val;
    logic [31:0]           rs2_val;
    logic                  out_valid;
    logic [31:0]           rd_data;
    logic                  rd_write;
    logic [31:0]           next_pc;
    logic                  illegal;

    integer seed = 32'h4140_5a0e;
    int     errors;
    int     checks;
    int     strobes;
    int     cycles;

    // expectations wait here until the matching output strobe
    logic [31:0] q_data[$];
    logic [31:0] q_pc[$];
    logic        q_write[$];
    logic        q_ill[$];
    logic        q_chk[$];
    logic [31:0] exp_data;
    logic [31:0] exp_pc;
    logic        exp_write;
    logic        exp_ill;
    logic        exp_chk;

    exec_stage i_exec_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .instr     (instr),
        .pc        (pc),
        .rs1_val   (rs1_val),
        .rs2_val   (rs2_val),
        .out_valid (out_valid),
        .rd_data   (rd_data),
        .rd_write  (rd_write),
        .next_pc   (next_pc),
        .illegal   (illegal)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Done: errors found");
            $finish;
        end
    end

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    function automatic logic less_signed(input logic [31:0] a, input logic [31:0] b);
        less_signed = (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
    endfunction

    // alt selects subtract for funct3 0 and arithmetic shift for funct3 5
    function automatic logic [31:0] base_op(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        logic [63:0] shr;
        shr = {{32{a[31]}}, a} >> b[4:0];
        case (f3)
            3'd0:    base_op = alt ? a - b : a + b;
            3'd1:    base_op = a << b[4:0];
            3'd2:    base_op = {31'd0, less_signed(a, b)};
            3'd3:    base_op = {31'd0, a < b};
            3'd4:    base_op = a ^ b;
            3'd5:    base_op = alt ? shr[31:0] : a >> b[4:0];
            3'd6:    base_op = a | b;
            default: base_op = a & b;
        endcase
    endfunction

    function automatic logic [31:0] muldiv_op(input logic [2:0] f3,
                                              input logic [31:0] a, input logic [31:0] b);
        logic [63:0] sa;
        logic [63:0] sb;
        logic [63:0] ub;
        logic [63:0] prod;
        logic [31:0] ma;
        logic [31:0] mb;
        logic [31:0] q;
        logic [31:0] r;
        sa = {{32{a[31]}}, a};
        sb = {{32{b[31]}}, b};
        ub = {32'd0, b};
        ma = a[31] ? -a : a;
        mb = b[31] ? -b : b;
        case (f3)
            3'd0, 3'd1: prod = sa * sb;
            3'd2:       prod = sa * ub;
            default:    prod = {32'd0, a} * ub;
        endcase
        // magnitudes make the overflow case fall out as the most negative value
        if (f3 < 3'd4) begin
            muldiv_op = (f3 == 3'd0) ? prod[31:0] : prod[63:32];
        end else if (b == 32'd0) begin
            muldiv_op = f3[1] ? a : 32'hFFFF_FFFF;
        end else if (f3 == 3'd4) begin
            q = ma / mb;
            muldiv_op = (a[31] ^ b[31]) ? -q : q;
        end else if (f3 == 3'd5) begin
            muldiv_op = a / b;
        end else if (f3 == 3'd6) begin
            r = ma % mb;
            muldiv_op = a[31] ? -r : r;
        end else begin
            muldiv_op = a % b;
        end
    endfunction

    task automatic predict(input logic [31:0] w, input logic [31:0] p,
                           input logic [31:0] a, input logic [31:0] b,
                           output logic [31:0] data, output logic [31:0] npc,
                           output logic wr, output logic ill, output logic chk);
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] imm;
        logic [31:0] boff;
        logic        alu_op;
        logic        tk;
        f3 = w[14:12];
        f7 = w[31:25];
        imm = {{20{w[31]}}, w[31:20]};
        boff = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        data = 32'd0;
        ill = 1'b0;
        alu_op = 1'b0;
        tk = 1'b0;
        case (w[6:0])
            riscv_defines::OPC_OP: begin
                alu_op = 1'b1;
                if (f7 == 7'h00) data = base_op(f3, 1'b0, a, b);
                else if (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)) data = base_op(f3, 1'b1, a, b);
                else if (f7 == 7'h01) data = muldiv_op(f3, a, b);
                else ill = 1'b1;
            end
            riscv_defines::OPC_OP_IMM: begin
                alu_op = 1'b1;
                data = base_op(f3, (f3 == 3'd5) && f7[5], a, imm);
                if (f3 == 3'd1) ill = (f7 != 7'h00);
                if (f3 == 3'd5) ill = (f7 != 7'h00) && (f7 != 7'h20);
            end
            riscv_defines::OPC_BRANCH: begin
                ill = (f3 == 3'd2) || (f3 == 3'd3);
                case (f3)
                    3'd0:    tk = (a == b);
                    3'd1:    tk = (a != b);
                    3'd4:    tk = less_signed(a, b);
                    3'd5:    tk = !less_signed(a, b);
                    3'd6:    tk = (a < b);
                    3'd7:    tk = (a >= b);
                    default: tk = 1'b0;
                endcase
            end
            default: ill = 1'b1;
        endcase
        chk = alu_op && !ill;
        wr = chk && (w[11:7] != 5'd0);
        npc = (tk && !ill) ? p + boff : p + 32'd4;
    endtask

    function automatic logic [31:0] bias_operand(input logic [31:0] r);
        case (r[2:0])
            3'd0:    bias_operand = 32'd0;
            3'd1:    bias_operand = 32'hFFFF_FFFF;
            3'd2:    bias_operand = 32'h8000_0000;
            3'd3:    bias_operand = 32'd1;
            default: bias_operand = r;
        endcase
    endfunction

    task automatic send(input logic [31:0] w, input logic [31:0] p,
                        input logic [31:0] a, input logic [31:0] b);
        logic [31:0] data;
        logic [31:0] npc;
        logic        wr;
        logic        ill;
        logic        chk;
        predict(w, p, a, b, data, npc, wr, ill, chk);
        @(negedge clk);
        in_valid = 1'b1;
        instr = w;
        pc = p;
        rs1_val = a;
        rs2_val = b;
        q_data.push_back(data);
        q_pc.push_back(npc);
        q_write.push_back(wr);
        q_ill.push_back(ill);
        q_chk.push_back(chk);
        strobes++;
    endtask

    // kind 0 base OP, 1 M extension, 2 OP-IMM, 3 branch, 4 unsupported
    task automatic run_test(input int kind, input int count, input string name);
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] p;
        logic [31:0] r;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [6:0]  opc;
        int          start_errors;
        start_errors = errors;
        for (int n = 0; n < count; n++) begin
            w = $random(seed);
            a = $random(seed);
            b = $random(seed);
            p = $random(seed);
            r = $random(seed);
            p[1:0] = 2'b00;
            f3 = w[14:12];
            case (kind)
                0: begin
                    f7 = ((f3 == 3'd0 || f3 == 3'd5) && r[8]) ? riscv_defines::F7_ALT
                                                              : riscv_defines::F7_BASE;
                    w = {f7, w[24:7], riscv_defines::OPC_OP};
                end
                1: begin
                    w = {riscv_defines::F7_MULDIV, w[24:7], riscv_defines::OPC_OP};
                    a = bias_operand(a);
                    b = bias_operand(b);
                end
                2: begin
                    if (f3 == 3'd1 || f3 == 3'd5) begin
                        case (r[1:0])
                            2'd0:    f7 = riscv_defines::F7_BASE;
                            2'd1:    f7 = riscv_defines::F7_ALT;
                            default: f7 = w[31:25];
                        endcase
                        w = {f7, w[24:7], riscv_defines::OPC_OP_IMM};
                    end else begin
                        w = {w[31:7], riscv_defines::OPC_OP_IMM};
                    end
                end
                3: begin
                    f3 = (r[2:1] == 2'b01) ? r[2:0] ^ 3'b100 : r[2:0];
                    w = {w[31:15], f3, w[11:7], riscv_defines::OPC_BRANCH};
                    case (r[4:3])
                        2'd0: b = a;
                        2'd1: b = a + {{29{r[7]}}, r[7:5]};
                        2'd2: begin
                            a = {~r[8], a[30:0]};
                            b = {r[8], b[30:0]};
                        end
                        default: ;
                    endcase
                end
                default: begin
                    opc = w[6:0];
                    while (opc == riscv_defines::OPC_OP || opc == riscv_defines::OPC_OP_IMM ||
                           opc == riscv_defines::OPC_BRANCH) begin
                        opc = $random(seed);
                    end
                    if (r[1:0] == 2'd0) begin
                        w = {w[31:15], 2'b01, r[2], w[11:7], riscv_defines::OPC_BRANCH};
                    end else begin
                        w = {w[31:7], opc};
                    end
                end
            endcase
            if (kind < 3 && r[7:5] == 3'd0) w[11:7] = 5'd0;
            send(w, p, a, b);
            if (r[31]) begin
                @(negedge clk);
                in_valid = 1'b0;
            end
        end
        @(negedge clk);
        in_valid = 1'b0;
        while (q_data.size() != 0) @(negedge clk);
        $display("test %s: %0d strobes, %0d errors", name, count, errors - start_errors);
    endtask

    // outputs change on the rising edge and are compared on the falling edge
    always @(negedge clk) begin
        if (rst_n && out_valid) begin
            if (q_data.size() == 0) begin
                $display("unexpected output strobe at %0t with no instruction pending", $time);
                errors++;
            end else begin
                exp_data = q_data.pop_front();
                exp_pc = q_pc.pop_front();
                exp_write = q_write.pop_front();
                exp_ill = q_ill.pop_front();
                exp_chk = q_chk.pop_front();
                if (exp_chk) check_word(rd_data, exp_data, "rd_data");
                check_word(next_pc, exp_pc, "next_pc");
                check_flag(rd_write, exp_write, "rd_write");
                check_flag(illegal, exp_ill, "illegal");
            end
        end
    end

    initial begin
        rst_n = 1'b0;
        in_valid = 1'b0;
        instr = '0;
        pc = 32'd0;
        rs1_val = 32'd0;
        rs2_val = 32'd0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        repeat (4) begin
            @(negedge clk);
            check_flag(out_valid, 1'b0, "out_valid after reset");
            check_flag(rd_write, 1'b0, "rd_write after reset");
            check_flag(illegal, 1'b0, "illegal after reset");
        end
        check_word(rd_data, 32'd0, "rd_data after reset");
        check_word(next_pc, 32'd0, "next_pc after reset");
        $display("test reset: %0d errors", errors);
        run_test(0, 400, "base_op");
        run_test(1, 400, "muldiv");
        run_test(2, 400, "op_imm");
        run_test(3, 400, "branch");
        run_test(4, 200, "unsupported");
        if (i_exec_stage.i_exec_stage_props.fail_count != 0) begin
            $display("bound assertions failed %0d times during the run",
                     i_exec_stage.i_exec_stage_props.fail_count);
            errors += i_exec_stage.i_exec_stage_props.fail_count;
        end
        $display("summary: %0d strobes, %0d checks, %0d errors", strobes, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* tb.f */
rtl/riscv_defines.sv
rtl/alu_decoder.sv
rtl/alu.sv
rtl/branch_unit.sv
rtl/exec_result.sv
rtl/exec_stage.sv
dv/exec_stage_props.sv
dv/exec_stage_tb.sv

/* Bender.yml */
package:
  name: exec_stage

sources:
  - rtl/riscv_defines.sv
  - rtl/alu_decoder.sv
  - rtl/alu.sv
  - rtl/branch_unit.sv
  - rtl/exec_result.sv
  - rtl/exec_stage.sv
  - target: test
    files:
      - dv/exec_stage_props.sv
      - dv/exec_stage_tb.sv
